/* verilog/dispatch_pkg.sv */
package dispatch_pkg;

  // number of cpu ports sharing the memory
  localparam int N_CPU = 4;

  // bits needed to name one port
  localparam int IDX_W = $clog2(N_CPU);

  // external memory address width
  localparam int ADDR_W = 16;

  // word width on both sides
  localparam int DATA_W = 32;

  // index of one cpu port
  typedef logic [IDX_W-1:0] cpu_idx_t;

  // one cpu request as seen on its port
  typedef struct packed {
    // high for a write, low for a read
    logic              wr;
    logic [ADDR_W-1:0] addr;
    // write data, ignored on reads
    logic [DATA_W-1:0] data;
  } cpu_req_t;

  // request word sent out to the external memory
  typedef struct packed {
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  // current holder of the memory bus
  typedef enum logic [1:0] {
    // bus free, next owner is chosen here
    OWN_NONE = 2'd0,
    // one granted cpu port
    OWN_CPU  = 2'd1,
    // external bus master
    OWN_EXT  = 2'd2
  } owner_t;

endpackage

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
  import dispatch_pkg::*;
(
  input  logic             clk,
  input  logic             ext_rst_e,
  // raw request lines of all cpu ports
  input  logic [N_CPU-1:0] cpu_req,
  // external master asks for the bus
  input  logic             ext_bus_q,
  // granted cpu handshake has closed
  input  logic             xfer_done,
  output logic             ext_bus_allow,
  output logic             grant_valid,
  output cpu_idx_t         grant_idx
);

  // who holds the bus right now
  owner_t   owner_q;

  // first port looked at on the next scan
  // always one past the last granted port
  cpu_idx_t rr_ptr;

  // scan result for this cycle
  logic     pick_valid;
  cpu_idx_t pick_idx;

  // round-robin scan starting at rr_ptr
  always_comb begin
    cpu_idx_t cand;
    cand       = rr_ptr;
    pick_valid = 1'b0;
    pick_idx   = rr_ptr;
    // walk from the far end back toward the pointer
    // so the nearest requesting port is the last one kept
    for (int k = N_CPU - 1; k >= 0; k--) begin
      cand = rr_ptr + cpu_idx_t'(k);
      if (cpu_req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // ownership tracking
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      owner_q   <= OWN_NONE;
      rr_ptr    <= '0;
      grant_idx <= '0;
    end else begin
      case (owner_q)
        OWN_NONE: begin
          // external master wins whenever the bus is idle
          if (ext_bus_q) begin
            owner_q <= OWN_EXT;
          end else if (pick_valid) begin
            owner_q   <= OWN_CPU;
            grant_idx <= pick_idx;
            // next scan starts just after this port
            rr_ptr    <= pick_idx + cpu_idx_t'(1);
          end
        end
        OWN_CPU: begin
          // hold until the cpu side is fully closed
          // then one idle cycle to sample requests fresh
          if (xfer_done) begin
            owner_q <= OWN_NONE;
          end
        end
        OWN_EXT: begin
          // master let go, bus goes idle again
          if (!ext_bus_q) begin
            owner_q <= OWN_NONE;
          end
        end
        default: begin
          owner_q <= OWN_NONE;
        end
      endcase
    end
  end

  // outputs are plain decodes of the owner register
  assign grant_valid   = (owner_q == OWN_CPU);

  // allow drops one cycle after ext_bus_q falls
  assign ext_bus_allow = (owner_q == OWN_EXT);

endmodule

/* verilog/mem_access.sv */
`timescale 1ns/1ps

module mem_access
  import dispatch_pkg::*;
(
  input  logic                 clk,
  input  logic                 ext_rst_e,
  // grant from the arbiter
  input  logic                 grant_valid,
  input  cpu_idx_t             grant_idx,
  // cpu ports
  input  logic [N_CPU-1:0]     cpu_req,
  input  cpu_req_t [N_CPU-1:0] cpu_cmd,
  output logic [N_CPU-1:0]     cpu_ack,
  output logic [DATA_W-1:0]    cpu_rdata,
  // external memory
  output logic                 mem_req,
  output mem_req_t             mem_cmd,
  input  logic                 mem_ack,
  input  logic [DATA_W-1:0]    mem_rdata,
  // back to the arbiter
  output logic                 xfer_done
);

  typedef enum logic [1:0] {
    // waiting for a grant
    ST_IDLE    = 2'd0,
    // mem_req high, waiting for mem_ack
    ST_MEM_REQ = 2'd1,
    // cpu_ack high, waiting for mem_ack to fall
    ST_MEM_REL = 2'd2,
    // memory closed, waiting for the cpu to drop req
    ST_CPU_ACK = 2'd3
  } state_t;

  state_t   state_q;

  // port this transaction belongs to
  cpu_idx_t cur_idx;

  // the old grant is still visible while xfer_done pulses
  logic start;
  assign start = grant_valid && !xfer_done;

  // only the granted port's req closes the handshake
  logic cur_req;
  assign cur_req = cpu_req[cur_idx];

  // first cycle the memory answers
  logic ack_seen;
  assign ack_seen = (state_q == ST_MEM_REQ) && mem_ack;

  // handshake control
  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state_q   <= ST_IDLE;
      cur_idx   <= '0;
      mem_req   <= 1'b0;
      cpu_ack   <= '0;
      xfer_done <= 1'b0;
    end else begin
      // single cycle pulse
      xfer_done <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            cur_idx <= grant_idx;
            mem_req <= 1'b1;
            state_q <= ST_MEM_REQ;
          end
        end
        ST_MEM_REQ: begin
          // ack the cpu and release memory together
          if (mem_ack) begin
            mem_req          <= 1'b0;
            cpu_ack[cur_idx] <= 1'b1;
            state_q          <= ST_MEM_REL;
          end
        end
        ST_MEM_REL: begin
          if (!mem_ack) begin
            // cpu may already have dropped req
            if (!cur_req) begin
              cpu_ack   <= '0;
              xfer_done <= 1'b1;
              state_q   <= ST_IDLE;
            end else begin
              state_q <= ST_CPU_ACK;
            end
          end
        end
        ST_CPU_ACK: begin
          if (!cur_req) begin
            cpu_ack   <= '0;
            xfer_done <= 1'b1;
            state_q   <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // request word and returned data
  always_ff @(posedge clk) begin
    // copy the granted command across to the memory format
    if (state_q == ST_IDLE && start) begin
      mem_cmd.wr   <= cpu_cmd[grant_idx].wr;
      mem_cmd.addr <= cpu_cmd[grant_idx].addr;
      mem_cmd.data <= cpu_cmd[grant_idx].data;
    end
    // writes complete with their own data word
    if (ack_seen) begin
      cpu_rdata <= mem_cmd.wr ? mem_cmd.data : mem_rdata;
    end
  end

endmodule

/* verilog/cpu_dispatcher.sv */
`timescale 1ns/1ps

module cpu_dispatcher
  import dispatch_pkg::*;
(
  input  logic                 clk,
  input  logic                 ext_rst_e,
  // cpu ports
  input  logic [N_CPU-1:0]     cpu_req,
  input  cpu_req_t [N_CPU-1:0] cpu_cmd,
  output logic [N_CPU-1:0]     cpu_ack,
  output logic [DATA_W-1:0]    cpu_rdata,
  // external memory
  output logic                 mem_req,
  output mem_req_t             mem_cmd,
  input  logic                 mem_ack,
  input  logic [DATA_W-1:0]    mem_rdata,
  // external bus master
  input  logic                 ext_bus_q,
  output logic                 ext_bus_allow
);

  // arbiter to memory access unit
  logic     grant_valid;
  cpu_idx_t grant_idx;
  // memory access unit back to arbiter
  logic     xfer_done;

  // decides who owns the memory bus
  bus_arbiter u_arbiter (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_req       (cpu_req),
    .ext_bus_q     (ext_bus_q),
    .xfer_done     (xfer_done),
    .ext_bus_allow (ext_bus_allow),
    .grant_valid   (grant_valid),
    .grant_idx     (grant_idx)
  );

  // runs one transaction for the granted port
  mem_access u_mem_access (
    .clk         (clk),
    .ext_rst_e   (ext_rst_e),
    .grant_valid (grant_valid),
    .grant_idx   (grant_idx),
    .cpu_req     (cpu_req),
    .cpu_cmd     (cpu_cmd),
    .cpu_ack     (cpu_ack),
    .cpu_rdata   (cpu_rdata),
    .mem_req     (mem_req),
    .mem_cmd     (mem_cmd),
    .mem_ack     (mem_ack),
    .mem_rdata   (mem_rdata),
    .xfer_done   (xfer_done)
  );

endmodule

/* test/dispatcher_properties.sv */
`timescale 1ns/1ps

module dispatcher_properties
  import dispatch_pkg::*;
(
  input logic             clk,
  input logic             ext_rst_e,
  input logic [N_CPU-1:0] cpu_req,
  input logic [N_CPU-1:0] cpu_ack,
  input logic             mem_req,
  input mem_req_t         mem_cmd,
  input logic             ext_bus_allow
);

  // master and memory side never hold the bus together
  a_bus_exclusive: assert property (
    @(posedge clk) disable iff (ext_rst_e) !(ext_bus_allow && mem_req)
  ) else $error("ext_bus_allow and mem_req high in the same cycle");

  // only the granted port sees an ack
  a_single_ack: assert property (
    @(posedge clk) disable iff (ext_rst_e) $onehot0(cpu_ack)
  ) else $error("more than one cpu_ack high");

  // command word frozen for the whole memory request
  a_cmd_stable: assert property (
    @(posedge clk) disable iff (ext_rst_e)
      (mem_req && $past(mem_req)) |-> (mem_cmd == $past(mem_cmd))
  ) else $error("mem_cmd changed while mem_req high");

  // ack needs req now, or req dropped last cycle in the closing phase
  a_ack_has_req: assert property (
    @(posedge clk) disable iff (ext_rst_e) (cpu_ack & ~(cpu_req | $past(cpu_req))) == '0
  ) else $error("cpu_ack high without its cpu_req");

endmodule

// attached to every dispatcher instance
bind cpu_dispatcher dispatcher_properties u_properties (
  .clk           (clk),
  .ext_rst_e     (ext_rst_e),
  .cpu_req       (cpu_req),
  .cpu_ack       (cpu_ack),
  .mem_req       (mem_req),
  .mem_cmd       (mem_cmd),
  .ext_bus_allow (ext_bus_allow)
);

/* test/tb_dispatcher.sv */
`timescale 1ns/1ps

module tb_dispatcher
  import dispatch_pkg::*;
();

  // operations per cpu with the first ones back to back
  localparam int N_OPS           = 24;
  localparam int N_FAIR_OPS      = 8;
  localparam int MEM_DEPTH       = 256;
  localparam int SEED            = 32'h1a5d02c7;
  localparam int RST_CYCLES      = 5;
  // external master steps in after this many completions
  localparam int EXT_AFTER       = 48;
  localparam int EXT_HOLD        = 12;
  localparam int WATCHDOG_CYCLES = N_CPU * N_OPS * 40;

  logic                 clk;
  logic                 ext_rst_e;
  logic [N_CPU-1:0]     cpu_req;
  cpu_req_t [N_CPU-1:0] cpu_cmd;
  logic [N_CPU-1:0]     cpu_ack;
  logic [DATA_W-1:0]    cpu_rdata;
  logic                 mem_req;
  mem_req_t             mem_cmd;
  logic                 mem_ack;
  logic [DATA_W-1:0]    mem_rdata;
  logic                 ext_bus_q;
  logic                 ext_bus_allow;

  // memory model contents and the expected image of it
  logic [DATA_W-1:0] mem_model [MEM_DEPTH];
  logic [DATA_W-1:0] shadow [MEM_DEPTH];

  logic             start_ops;
  logic [N_CPU-1:0] cpu_done;
  logic             ext_done;
  // completed cpu handshakes
  int               done_cnt;

  cpu_dispatcher DUT (
    .clk           (clk),
    .ext_rst_e     (ext_rst_e),
    .cpu_req       (cpu_req),
    .cpu_cmd       (cpu_cmd),
    .cpu_ack       (cpu_ack),
    .cpu_rdata     (cpu_rdata),
    .mem_req       (mem_req),
    .mem_cmd       (mem_cmd),
    .mem_ack       (mem_ack),
    .mem_rdata     (mem_rdata),
    .ext_bus_q     (ext_bus_q),
    .ext_bus_allow (ext_bus_allow)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // power-up word built from all address bits
  function automatic logic [DATA_W-1:0] fill_word(input logic [7:0] a);
    return {8'hc3, a, ~a, a ^ 8'h5a};
  endfunction

  // writes echo their data while reads see the last word written
  function automatic logic [DATA_W-1:0] ref_access(input mem_req_t cmd);
    if (cmd.wr) begin
      return cmd.data;
    end else begin
      return shadow[cmd.addr[7:0]];
    end
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one request loop per cpu port
  for (genvar g = 0; g < N_CPU; g++) begin : cpu_model
    logic     req_l;
    cpu_req_t cmd_l;
    logic     done_l;

    assign cpu_req[g]  = req_l;
    assign cpu_cmd[g]  = cmd_l;
    assign cpu_done[g] = done_l;

    initial begin
      cpu_req_t nxt;
      int       seed_l;
      int       r;
      int       op;
      req_l  <= 1'b0;
      cmd_l  <= '0;
      done_l <= 1'b0;
      seed_l = SEED ^ g;
      wait (start_ops);
      for (op = 0; op < N_OPS; op++) begin
        r = $random(seed_l);
        // idle gaps only after the back-to-back rounds
        if (op >= N_FAIR_OPS) begin
          repeat (int'(r[5:4])) @(posedge clk);
        end
        nxt.wr   = r[0];
        // small window so reads hit earlier writes
        nxt.addr = ADDR_W'(r[11:8]);
        nxt.data = $random(seed_l);
        @(posedge clk);
        cmd_l <= nxt;
        req_l <= 1'b1;
        do @(negedge clk); while (!cpu_ack[g]);
        // slow cpu keeps req up a few more cycles
        repeat (int'(r[7:6])) @(posedge clk);
        @(posedge clk);
        req_l <= 1'b0;
        // no new req until ack is low again
        do @(negedge clk); while (cpu_ack[g]);
      end
      done_l <= 1'b1;
    end
  end

  // four-phase external memory with 0 to 5 wait cycles
  initial begin : memory_model
    int         mseed;
    int         r;
    int         k;
    logic [7:0] a;
    mem_ack   <= 1'b0;
    mem_rdata <= '0;
    mseed = ~SEED;
    for (k = 0; k < MEM_DEPTH; k++) begin
      mem_model[k] = fill_word(k[7:0]);
    end
    forever begin
      @(negedge clk);
      if (mem_req && !mem_ack) begin
        r = $random(mseed);
        repeat (int'(r[2:0]) % 6) @(posedge clk);
        @(posedge clk);
        a = mem_cmd.addr[7:0];
        // a write returns the word it replaces
        mem_rdata <= mem_model[a];
        if (mem_cmd.wr) begin
          mem_model[a] = mem_cmd.data;
        end
        mem_ack   <= 1'b1;
      end else if (!mem_req && mem_ack) begin
        @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  // expected data taken at each mem_req rise and checked at cpu_ack rise
  initial begin : compare
    logic [N_CPU-1:0]  ack_prev;
    logic [N_CPU-1:0]  req_prev;
    logic              mreq_prev;
    mem_req_t          pend_cmd;
    logic [DATA_W-1:0] pend_exp;
    int                k;
    ack_prev  = '0;
    req_prev  = '0;
    mreq_prev = 1'b0;
    pend_cmd  = '0;
    pend_exp  = '0;
    done_cnt  = 0;
    for (k = 0; k < MEM_DEPTH; k++) begin
      shadow[k] = fill_word(k[7:0]);
    end
    forever begin
      @(negedge clk);
      if (mem_req && !mreq_prev) begin
        pend_cmd = mem_cmd;
        pend_exp = ref_access(mem_cmd);
        if (mem_cmd.wr) begin
          shadow[mem_cmd.addr[7:0]] = mem_cmd.data;
        end
      end
      for (k = 0; k < N_CPU; k++) begin
        if (cpu_ack[k] && !ack_prev[k]) begin
          check_value(64'(cpu_req[k]), 64'd1, "cpu_ack rose without cpu_req");
          check_value(64'(cpu_cmd[k]), 64'(pend_cmd), "acked port does not match mem_cmd");
          check_value(64'(cpu_rdata), 64'(pend_exp), "cpu_rdata mismatch");
          // strict rotation while every port keeps requesting
          if (done_cnt < N_CPU * N_FAIR_OPS) begin
            check_value(64'(k), 64'(done_cnt % N_CPU), "round-robin order");
          end
          done_cnt++;
        end
        // req must already have been low one cycle earlier
        if (!cpu_ack[k] && ack_prev[k]) begin
          check_value(64'(req_prev[k]), 64'd0, "cpu_ack fell before cpu_req was low");
        end
      end
      ack_prev  = cpu_ack;
      req_prev  = cpu_req;
      mreq_prev = mem_req;
    end
  end

  // external master grabs the bus midway through the random phase
  initial begin : ext_master
    int hold;
    int cnt_at_req;
    ext_bus_q <= 1'b0;
    ext_done  <= 1'b0;
    do @(posedge clk); while (done_cnt < EXT_AFTER);
    ext_bus_q <= 1'b1;
    cnt_at_req = done_cnt;
    do @(negedge clk); while (!ext_bus_allow);
    // only the transaction already running may finish first
    check_value(64'(done_cnt), 64'(cnt_at_req), "cpu serviced ahead of the waiting master");
    for (hold = 0; hold < EXT_HOLD; hold++) begin
      check_value(64'(mem_req), 64'd0, "mem_req high while master owns the bus");
      check_value(64'(cpu_ack), 64'd0, "cpu_ack high while master owns the bus");
      check_value(64'(ext_bus_allow), 64'd1, "ext_bus_allow fell with ext_bus_q held");
      @(negedge clk);
    end
    @(posedge clk);
    ext_bus_q <= 1'b0;
    @(negedge clk);
    check_value(64'(ext_bus_allow), 64'd1, "ext_bus_allow fell too early");
    @(negedge clk);
    check_value(64'(ext_bus_allow), 64'd0, "ext_bus_allow high one cycle after release");
    ext_done <= 1'b1;
  end

  initial begin : watchdog
    repeat (RST_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
    $display("ERROR: no completion after %0d cycles, simulation hung", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : main_seq
    ext_rst_e <= 1'b1;
    start_ops <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    ext_rst_e <= 1'b0;
    @(negedge clk);
    check_value(64'(cpu_ack), 64'd0, "cpu_ack after reset");
    check_value(64'(mem_req), 64'd0, "mem_req after reset");
    check_value(64'(ext_bus_allow), 64'd0, "ext_bus_allow after reset");
    @(posedge clk);
    start_ops <= 1'b1;
    wait (&cpu_done && ext_done);
    @(posedge clk);
    check_value(64'(done_cnt), 64'(N_CPU * N_OPS), "completed operations");
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* tb.f */
verilog/dispatch_pkg.sv
verilog/bus_arbiter.sv
verilog/mem_access.sv
verilog/cpu_dispatcher.sv
test/dispatcher_properties.sv
test/tb_dispatcher.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dispatcher testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_dispatcher \
  -f tb.f \
  -o tb_dispatcher_sim

# pipe status comes from tee, so the log search below always runs
./obj_dir/tb_dispatcher_sim 2>&1 | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "result: FAIL"
  exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
  echo "result: run ended without a pass line"
  exit 1
fi

echo "result: PASS"
